//--- verif/lstm_gate_tests.txt
# op x_vec w_x (lane 7 first), then h_vec w_h (lane 3 first) bias expected, all hex
# op 0 is hard sigmoid, 1 is hard tanh, 2 is none; words are Q7.8
2 00000000000000000000000000000100 00000000000000000000000000000200
0000000000000000 0000000000000000 0000 0200
2 000000000000000000000000FF000000 00000000000000000000000001800000
0000000000000100 0000000000000100 0010 FF90
2 01000100010001000100010001000100 01000100010001000100010001000100
0100010001000100 0100010001000100 0100 0D00
2 000000000000000000000000FFFF0001 00000000000000000000000000010001
0000000000000000 0000000000000000 0000 FFFF
2 00000000000000000000000000007F00 00000000000000000000000000007F00
0000000000000000 0000000000000000 0000 7FFF
2 00000000000000000000000000008000 00000000000000000000000000007FFF
0000000000000000 0000000000000000 0000 8000
2 00000000000000000000000040004000 00000000000000000000000001000100
0000000000000000 0000000000000000 0000 7FFF
2 0000000000000000C000C000C000C000 00000000000000000100010001000100
0000000000004000 0000000000000100 1000 8000
2 00000000000000000000000000000300 00000000000000000000000000000100
0000000000000300 000000000000FF00 0005 0005
2 7FFF7FFF7FFF7FFF7FFF7FFF7FFF7FFF 7FFF7FFF7FFF7FFF7FFF7FFF7FFF7FFF
8000800080008000 7FFF7FFF7FFF7FFF 0000 7FFF
2 00000000000000000000FE0000000000 00000000000000000000FF8000000000
0000000000000000 0000000000000000 FF00 0000
0 00000000000000000000000000000000 00000000000000000000000000000000
0000000000000000 0000000000000000 0000 0080
0 00000000000000000000000000000000 00000000000000000000000000000000
0000000000000000 0000000000000000 0100 00C0
0 00000000000000000000000000000000 00000000000000000000000000000000
0000000000000000 0000000000000000 FF00 0040
0 00000000000000000000000000000000 00000000000000000000000000000000
0000000000000000 0000000000000000 0200 0100
0 00000000000000000000000000001000 00000000000000000000000000000100
0000000000000000 0000000000000000 0000 0100
0 00000000000000000000000000000000 00000000000000000000000000000000
000000000000F000 0000000000000100 0000 0000
0 00000000000000000000000000000000 00000000000000000000000000000000
0000000000000000 0000000000000000 FFFD 007F
1 00000000000000000000000000000000 00000000000000000000000000000000
0000000000000000 0000000000000000 0080 0080
1 00000000000000000000000000000400 00000000000000000000000000000100
0000000000000000 0000000000000000 0000 0100
1 00000000000000000000000000000000 00000000000000000000000000000000
000000000000FC00 0000000000000100 0000 FF00

//--- sources.f
source/lstm_pkg.sv
source/signedmul.sv
source/vecmat_mul.sv
source/vecmat_add.sv
source/gate_activation.sv
source/lstm_gate.sv
verif/lstm_gate_asserts.sv
verif/lstm_gate_tb.sv

//--- Makefile
TOP = lstm_gate_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) \
		-f sources.f

clean:
	rm -rf obj_dir

//--- verif/lstm_gate_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lstm_gate_tb;
	import lstm_pkg::*;

	localparam int x_len = 8;
	localparam int h_len = 4;
	localparam int random_cases = 200;
	localparam int drain_limit = 64;
	localparam int quiet_cycles = 20;

	logic clk;
	logic reset;
	logic in_valid;
	act_op_t op;
	logic [x_len*data_width-1:0] x_vec;
	logic [x_len*data_width-1:0] w_x;
	logic [h_len*data_width-1:0] h_vec;
	logic [h_len*data_width-1:0] w_h;
	logic signed [data_width-1:0] bias;
	logic out_valid;
	logic signed [data_width-1:0] gate_out;

	logic [data_width-1:0] expected_q [$]; // one entry per issue in issue order
	integer seed;

	lstm_gate #(.x_len(x_len), .h_len(h_len)) DUT (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.op(op),
		.x_vec(x_vec),
		.w_x(w_x),
		.h_vec(h_vec),
		.w_h(w_h),
		.bias(bias),
		.out_valid(out_valid),
		.gate_out(gate_out)
	);

	always #2 clk = ~clk;

	task automatic abort_run(input string why);
		$display("Errors found");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input logic [data_width-1:0] got,
			input logic [data_width-1:0] want, input string what);
		if (got !== want) begin
			$display("Fail at time %0t: %s got %h expected %h", $time, what, got, want);
			abort_run("stopped at the first mismatch");
		end
	endtask

	function automatic longint saturate_word(input longint v);
		if (v > 32767)
			return 32767;
		else if (v < -32768)
			return -32768;
		else
			return v;
	endfunction

	function automatic longint lane_product(input logic signed [data_width-1:0] a,
			input logic signed [data_width-1:0] b);
		longint p;
		p = longint'(a) * longint'(b);
		return saturate_word(p >>> frac_bits); // floor then clamp
	endfunction

	task automatic compute_expected(input act_op_t op_sel,
			input logic [x_len*data_width-1:0] xv, input logic [x_len*data_width-1:0] wx,
			input logic [h_len*data_width-1:0] hv, input logic [h_len*data_width-1:0] wh,
			input logic signed [data_width-1:0] b, output logic [data_width-1:0] y);
		longint acc;
		longint pre;
		longint hs;
		acc = 0;
		for (int i = 0; i < x_len; i++)
			acc += lane_product(xv[i*data_width +: data_width], wx[i*data_width +: data_width]);
		for (int i = 0; i < h_len; i++)
			acc += lane_product(hv[i*data_width +: data_width], wh[i*data_width +: data_width]);
		pre = saturate_word(acc + longint'(b));
		case (op_sel)
			act_sigmoid: begin
				hs = (pre >>> 2) + 128;
				if (hs < 0)
					hs = 0;
				else if (hs > 256)
					hs = 256;
				y = hs[data_width-1:0];
			end
			act_tanh: begin
				if (pre < -256)
					pre = -256;
				else if (pre > 256)
					pre = 256;
				y = pre[data_width-1:0];
			end
			default: y = pre[data_width-1:0];
		endcase
	endtask

	function automatic logic [data_width-1:0] random_word(input bit wide, input int span);
		int r;
		r = $random(seed);
		if (wide)
			return r[data_width-1:0];
		else
			return r % span;
	endfunction

	task automatic issue(input act_op_t op_sel,
			input logic [x_len*data_width-1:0] xv, input logic [x_len*data_width-1:0] wx,
			input logic [h_len*data_width-1:0] hv, input logic [h_len*data_width-1:0] wh,
			input logic signed [data_width-1:0] b, input logic [data_width-1:0] want);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		op = op_sel;
		x_vec = xv;
		w_x = wx;
		h_vec = hv;
		w_h = wh;
		bias = b;
		expected_q.push_back(want);
	endtask

	task automatic idle();
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic watch_idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (out_valid !== 1'b0)
				abort_run("out_valid was not low while no issue was outstanding");
		end
	endtask

	task automatic wait_drain(input int limit);
		int cycles;
		cycles = 0;
		while (expected_q.size() != 0) begin
			@(posedge clk);
			cycles++;
			if (cycles > limit)
				abort_run("timed out waiting for outstanding results");
		end
	endtask

	task automatic run_file_cases();
		int fd;
		int n_read;
		int n_cases;
		bit at_end;
		logic [8*128-1:0] line;
		logic [7:0] op_raw;
		logic [x_len*data_width-1:0] xv;
		logic [x_len*data_width-1:0] wx;
		logic [h_len*data_width-1:0] hv;
		logic [h_len*data_width-1:0] wh;
		logic [data_width-1:0] b;
		logic [data_width-1:0] want;
		n_cases = 0;
		at_end = 1'b0;
		fd = $fopen("verif/lstm_gate_tests.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open verif/lstm_gate_tests.txt");
		end else begin
			n_read = $fgets(line, fd); // two column description lines
			n_read = $fgets(line, fd);
			while (!at_end && n_cases < 256) begin
				n_read = $fscanf(fd, "%h %h %h %h %h %h %h", op_raw, xv, wx, hv, wh, b, want);
				if (n_read == 7) begin
					issue(act_op_t'(op_raw[1:0]), xv, wx, hv, wh, b, want);
					idle(); // one gap cycle between directed issues
					n_cases++;
				end else begin
					at_end = 1'b1;
				end
			end
			$fclose(fd);
			if (n_cases == 0)
				abort_run("no test vectors found in the tests file");
		end
	endtask

	task automatic run_random_cases(input int count);
		logic [x_len*data_width-1:0] xv;
		logic [x_len*data_width-1:0] wx;
		logic [h_len*data_width-1:0] hv;
		logic [h_len*data_width-1:0] wh;
		logic signed [data_width-1:0] b;
		logic [data_width-1:0] want;
		act_op_t op_sel;
		bit wide;
		for (int n = 0; n < count; n++) begin
			wide = ({$random(seed)} % 8) == 0; // full range words now and then
			op_sel = act_op_t'({$random(seed)} % 3);
			for (int i = 0; i < x_len; i++) begin
				xv[i*data_width +: data_width] = random_word(wide, 2048);
				wx[i*data_width +: data_width] = random_word(wide, 512);
			end
			for (int i = 0; i < h_len; i++) begin
				hv[i*data_width +: data_width] = random_word(wide, 2048);
				wh[i*data_width +: data_width] = random_word(wide, 512);
			end
			b = random_word(wide, 1024);
			compute_expected(op_sel, xv, wx, hv, wh, b, want);
			issue(op_sel, xv, wx, hv, wh, b, want); // back to back
		end
		idle();
	endtask

	always @(negedge clk) begin : monitor
		logic [data_width-1:0] want;
		if (reset === 1'b1 && out_valid === 1'b1) begin
			if (expected_q.size() == 0) begin
				abort_run("out_valid rose with no issue outstanding");
			end else begin
				want = expected_q.pop_front();
				check_value(gate_out, want, "gate_out");
			end
		end
	end

	initial begin
		seed = 65224;
		clk = 1'b0;
		reset = 1'b0;
		in_valid = 1'b0;
		op = act_none;
		x_vec = '0;
		w_x = '0;
		h_vec = '0;
		w_h = '0;
		bias = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b1;
		watch_idle(10);
		run_file_cases();
		wait_drain(drain_limit);
		run_random_cases(random_cases);
		wait_drain(drain_limit);
		watch_idle(quiet_cycles); // nothing more may come out
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/lstm_gate_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module lstm_gate_asserts #(
	parameter int latency = 7
) (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire lstm_pkg::act_op_t op,
	input wire out_valid,
	input wire signed [lstm_pkg::data_width-1:0] gate_out
);
	import lstm_pkg::*;

	act_op_t op_hist [latency]; // one entry per pipeline cycle

	always_ff @(posedge clk) begin
		op_hist[0] <= op;
		for (int k = 1; k < latency; k++) begin
			op_hist[k] <= op_hist[k-1];
		end
	end

	reset_quiet: assert property (@(posedge clk) !reset |=> !out_valid)
		else $error("out_valid high during reset");

	release_quiet: assert property (@(posedge clk) !$past(reset) |=> !out_valid)
		else $error("out_valid high on the first cycle after reset");

	// fixed latency from issue to result
	strobe_latency: assert property (@(posedge clk) disable iff (!reset)
		out_valid == $past(in_valid, latency))
		else $error("out_valid does not follow in_valid by %0d cycles", latency);

	sigmoid_range: assert property (@(posedge clk) disable iff (!reset)
		(out_valid && op_hist[latency-1] == act_sigmoid) |->
			(gate_out >= 0 && gate_out <= one_fixed))
		else $error("hard sigmoid result %0d outside 0..256", gate_out);

endmodule

bind lstm_gate lstm_gate_asserts asserts_u (
	.clk(clk),
	.reset(reset),
	.in_valid(in_valid),
	.op(op),
	.out_valid(out_valid),
	.gate_out(gate_out)
);

`default_nettype wire

//--- source/lstm_gate.sv
`timescale 1ns/10ps
`default_nettype none

module lstm_gate #(
	parameter int x_len = 8,
	parameter int h_len = 4
) (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire lstm_pkg::act_op_t op,
	input wire [x_len*lstm_pkg::data_width-1:0] x_vec,
	input wire [x_len*lstm_pkg::data_width-1:0] w_x,
	input wire [h_len*lstm_pkg::data_width-1:0] h_vec,
	input wire [h_len*lstm_pkg::data_width-1:0] w_h,
	input wire signed [lstm_pkg::data_width-1:0] bias,
	output logic out_valid,
	output logic signed [lstm_pkg::data_width-1:0] gate_out
);
	import lstm_pkg::*;

	localparam int x_lvls = $clog2(x_len);
	localparam int h_lvls = $clog2(h_len);
	localparam int h_delay = x_lvls - h_lvls;
	localparam int x_sum_width = data_width + x_lvls;
	localparam int h_sum_width = data_width + h_lvls;
	localparam int pipe_depth = 2 + x_lvls; // multiply plus x tree

	logic [x_len*data_width-1:0] x_prod;
	logic [h_len*data_width-1:0] h_prod;
	logic signed [x_sum_width-1:0] x_sum;
	logic signed [h_sum_width-1:0] h_sum;
	logic signed [x_sum_width-1:0] h_ext;
	logic signed [x_sum_width-1:0] h_aligned;

	logic [pipe_depth-1:0] valid_pipe;
	act_op_t op_pipe [pipe_depth];
	logic signed [data_width-1:0] bias_pipe [pipe_depth];

	// input path
	vecmat_mul #(.vect_len(x_len)) x_mul (
		.clk(clk), .data(x_vec), .w(w_x), .products(x_prod)
	);
	vecmat_add #(.vect_len(x_len)) x_add (
		.clk(clk), .products(x_prod), .sum(x_sum)
	);

	// recurrent path
	vecmat_mul #(.vect_len(h_len)) h_mul (
		.clk(clk), .data(h_vec), .w(w_h), .products(h_prod)
	);
	vecmat_add #(.vect_len(h_len)) h_add (
		.clk(clk), .products(h_prod), .sum(h_sum)
	);

	assign h_ext = h_sum; // sign extends to the x sum width

	// shorter tree, so hold h sum until x sum catches up
	generate
		if (h_delay == 0) begin : no_delay
			assign h_aligned = h_ext;
		end else begin : h_pipe
			logic signed [x_sum_width-1:0] stage [h_delay];

			always_ff @(posedge clk) begin
				stage[0] <= h_ext;
				for (int k = 1; k < h_delay; k++) begin
					stage[k] <= stage[k-1];
				end
			end

			assign h_aligned = stage[h_delay-1];
		end
	endgenerate

	// strobe, op and bias follow the data through the datapath
	always_ff @(posedge clk) begin
		if (!reset)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[pipe_depth-2:0], in_valid};
	end

	always_ff @(posedge clk) begin
		op_pipe[0] <= op;
		bias_pipe[0] <= bias;
		for (int k = 1; k < pipe_depth; k++) begin
			op_pipe[k] <= op_pipe[k-1];
			bias_pipe[k] <= bias_pipe[k-1];
		end
	end

	gate_activation #(.sum_width(x_sum_width)) act (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_pipe[pipe_depth-1]),
		.op(op_pipe[pipe_depth-1]),
		.x_sum(x_sum),
		.h_sum(h_aligned),
		.bias(bias_pipe[pipe_depth-1]),
		.valid_out(out_valid),
		.y(gate_out)
	);

endmodule

`default_nettype wire

//--- source/gate_activation.sv
`timescale 1ns/10ps
`default_nettype none

module gate_activation #(
	parameter int sum_width = 19
) (
	input wire clk,
	input wire reset,
	input wire valid_in,
	input wire lstm_pkg::act_op_t op,
	input wire signed [sum_width-1:0] x_sum,
	input wire signed [sum_width-1:0] h_sum,
	input wire signed [lstm_pkg::data_width-1:0] bias,
	output logic valid_out,
	output logic signed [lstm_pkg::data_width-1:0] y
);
	import lstm_pkg::*;

	localparam int pre_width = sum_width + 2;
	localparam logic signed [pre_width-1:0] word_max = (2 ** (data_width - 1)) - 1;
	localparam logic signed [pre_width-1:0] word_min = -(2 ** (data_width - 1));

	logic signed [pre_width-1:0] pre_wide;
	logic signed [data_width-1:0] pre_q;
	logic signed [data_width-1:0] hs;
	act_op_t op_q;
	logic valid_q;

	assign pre_wide = x_sum + h_sum + bias; // two spare bits, cannot wrap

	// stage one: saturated pre-activation
	always_ff @(posedge clk) begin
		if (pre_wide > word_max)
			pre_q <= word_max[data_width-1:0];
		else if (pre_wide < word_min)
			pre_q <= word_min[data_width-1:0];
		else
			pre_q <= pre_wide[data_width-1:0];
		op_q <= op;
	end

	// x/4 + 0.5, range stays inside the word
	assign hs = (pre_q >>> 2) + half_fixed;

	// stage two: activation
	always_ff @(posedge clk) begin
		case (op_q)
			act_sigmoid: begin
				if (hs < 0)
					y <= '0;
				else if (hs > one_fixed)
					y <= one_fixed;
				else
					y <= hs;
			end
			act_tanh: begin
				if (pre_q < -one_fixed)
					y <= -one_fixed;
				else if (pre_q > one_fixed)
					y <= one_fixed;
				else
					y <= pre_q;
			end
			default: y <= pre_q; // act_none and the unused code
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			valid_q <= 1'b0;
			valid_out <= 1'b0;
		end else begin
			valid_q <= valid_in;
			valid_out <= valid_q;
		end
	end

endmodule

`default_nettype wire

//--- source/vecmat_add.sv
`timescale 1ns/10ps
`default_nettype none

module vecmat_add #(
	parameter int vect_len = 8
) (
	input wire clk,
	input wire [vect_len*lstm_pkg::data_width-1:0] products,
	output logic signed [lstm_pkg::data_width+$clog2(vect_len)-1:0] sum
);
	import lstm_pkg::*;

	localparam int levels = $clog2(vect_len);

	// level l holds vect_len >> (l+1) partial sums, each data_width+l+1 bits wide
	genvar l;
	generate
		for (l = 0; l < levels; l++) begin : lvl
			localparam int n = vect_len >> (l + 1);

			logic signed [data_width+l:0] node [n];

			if (l == 0) begin : leaf
				always_ff @(posedge clk) begin
					for (int i = 0; i < n; i++) begin
						node[i] <= $signed(products[2*i*data_width +: data_width])
							+ $signed(products[(2*i+1)*data_width +: data_width]);
					end
				end
			end else begin : inner
				// one extra bit per level, so no overflow check here
				always_ff @(posedge clk) begin
					for (int i = 0; i < n; i++) begin
						node[i] <= lvl[l-1].node[2*i] + lvl[l-1].node[2*i+1];
					end
				end
			end
		end
	endgenerate

	assign sum = lvl[levels-1].node[0]; // root of the tree

endmodule

`default_nettype wire

//--- source/vecmat_mul.sv
`timescale 1ns/10ps
`default_nettype none

module vecmat_mul #(
	parameter int vect_len = 8
) (
	input wire clk,
	input wire [vect_len*lstm_pkg::data_width-1:0] data,
	input wire [vect_len*lstm_pkg::data_width-1:0] w,
	output logic [vect_len*lstm_pkg::data_width-1:0] products
);
	import lstm_pkg::*;

	logic [vect_len*data_width-1:0] vector;
	logic [vect_len*data_width-1:0] matrix;

	// operand registers, loaded every cycle
	always_ff @(posedge clk) begin
		vector <= data;
		matrix <= w;
	end

	// one multiplier per lane, lane i at bits i*16 upward
	genvar j;
	generate
		for (j = 0; j < vect_len; j++) begin : lane
			signedmul mult_u (
				.clk(clk),
				.a(vector[j*data_width +: data_width]),
				.b(matrix[j*data_width +: data_width]),
				.c(products[j*data_width +: data_width])
			);
		end
	endgenerate

endmodule

`default_nettype wire

//--- source/signedmul.sv
`timescale 1ns/10ps
`default_nettype none

module signedmul (
	input wire clk,
	input wire signed [lstm_pkg::data_width-1:0] a,
	input wire signed [lstm_pkg::data_width-1:0] b,
	output logic signed [lstm_pkg::data_width-1:0] c
);
	import lstm_pkg::*;

	localparam int prod_width = 2 * data_width;
	localparam logic signed [prod_width-1:0] word_max = (2 ** (data_width - 1)) - 1;
	localparam logic signed [prod_width-1:0] word_min = -(2 ** (data_width - 1));

	logic signed [prod_width-1:0] prod;
	logic signed [prod_width-1:0] scaled;

	always_comb begin
		prod = a * b;
		scaled = prod >>> frac_bits; // truncates toward minus infinity
	end

	// large weights push the product past the word range
	always_ff @(posedge clk) begin
		if (scaled > word_max)
			c <= word_max[data_width-1:0];
		else if (scaled < word_min)
			c <= word_min[data_width-1:0];
		else
			c <= scaled[data_width-1:0];
	end

endmodule

`default_nettype wire

//--- source/lstm_pkg.sv
`default_nettype none

package lstm_pkg;

	// Q7.8 words throughout the gate
	localparam int data_width = 16;
	localparam int frac_bits = 8;

	localparam logic signed [data_width-1:0] one_fixed = 16'sd256;
	localparam logic signed [data_width-1:0] half_fixed = 16'sd128;

	// activation select, carried alongside the data
	typedef enum logic [1:0] {
		act_sigmoid = 2'd0,
		act_tanh = 2'd1,
		act_none = 2'd2
	} act_op_t;

endpackage

`default_nettype wire
